// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench
# Override any variable on the command line, e.g. make run JOBS=8

VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= sim passed

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
src/periph_pkg.sv
src/req_queue.sv
src/periph_decoder.sv
src/irq_ctrl.sv
src/timer_bank.sv
src/gpio_regs.sv
src/periph_top.sv
tb/tb_periph.sv

// ==== src/gpio_regs.sv ====
/*
 * GPIO block
 * LED output register and synchronized DIP switch input
 */

module gpio_regs import periph_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       sel_i,
  input  logic       we_i,
  input  logic [7:0] offset_i,
  input  reg_data_t  wdata_i,
  output reg_data_t  rdata_o,
  input  logic [7:0] dip_i,
  output logic [7:0] leds_o
);

  localparam logic [7:0] OffLeds = 8'h00;
  localparam logic [7:0] OffDip  = 8'h04;

  logic [7:0] dip_meta;
  logic [7:0] dip_sync;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      leds_o   <= '0;
      dip_meta <= '0;
      dip_sync <= '0;
    end else begin
      // Two flop synchronizer for the switches
      dip_meta <= dip_i;
      dip_sync <= dip_meta;
      if (sel_i && we_i && (offset_i == OffLeds)) begin
        leds_o <= wdata_i[7:0];
      end
    end
  end

  always_comb begin
    case (offset_i)
      OffLeds: rdata_o = {24'b0, leds_o};
      OffDip:  rdata_o = {24'b0, dip_sync};
      default: rdata_o = '0;
    endcase
  end

endmodule

// ==== src/irq_ctrl.sv ====
/*
 * Interrupt controller
 * Edge capture into PENDING, ENABLE mask and CLAIM of the
 * lowest enabled pending source
 */

module irq_ctrl import periph_pkg::*; #(
  parameter int NumSrc = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              sel_i,
  input  logic              we_i,
  input  logic [7:0]        offset_i,
  input  reg_data_t         wdata_i,
  output reg_data_t         rdata_o,
  input  logic [NumSrc-1:0] src_i,
  output logic              irq_o
);

  localparam logic [7:0] OffPending = 8'h00;
  localparam logic [7:0] OffEnable  = 8'h04;
  localparam logic [7:0] OffClaim   = 8'h08;

  logic [NumSrc-1:0] src_q;
  logic [NumSrc-1:0] pending_q;
  logic [NumSrc-1:0] enable_q;
  logic [NumSrc-1:0] active;
  logic [NumSrc-1:0] claim_mask;
  logic              claim_rd;
  reg_data_t         claim_id;

  assign active = pending_q & enable_q;

  // Isolate the lowest set bit
  assign claim_mask = active & (~active + 1'b1);
  assign claim_rd   = sel_i && !we_i && (offset_i == OffClaim);

  always_comb begin
    claim_id = '0;
    for (int i = NumSrc - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id = reg_data_t'(i + 1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      irq_o     <= 1'b0;
    end else begin
      src_q <= src_i;
      // A new edge wins over a claim in the same cycle
      pending_q <= (pending_q & ~(claim_rd ? claim_mask : '0)) | (src_i & ~src_q);
      if (sel_i && we_i && (offset_i == OffEnable)) begin
        enable_q <= wdata_i[NumSrc-1:0];
      end
      irq_o <= |active;
    end
  end

  always_comb begin
    case (offset_i)
      OffPending: rdata_o = reg_data_t'(pending_q);
      OffEnable:  rdata_o = reg_data_t'(enable_q);
      OffClaim:   rdata_o = claim_id;
      default:    rdata_o = '0;
    endcase
  end

endmodule

// ==== src/periph_decoder.sv ====
/*
 * Request decoder
 * Executes the queue head each cycle, strobes one target
 * and registers the response
 */

module periph_decoder import periph_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  reg_req_t   head_i,
  input  logic       valid_i,
  output logic       pop_o,
  output logic       sel_gpio_o,
  output logic       sel_timer_o,
  output logic       sel_irq_o,
  output logic       we_o,
  output logic [7:0] offset_o,
  output reg_data_t  wdata_o,
  input  reg_data_t  rdata_gpio_i,
  input  reg_data_t  rdata_timer_i,
  input  reg_data_t  rdata_irq_i,
  output logic       rsp_valid_o,
  output reg_rsp_t   rsp_o
);

  periph_sel_e sel;
  reg_rsp_t    rsp_d;

  // ----------------------------------------
  // Target decode
  // ----------------------------------------
  always_comb begin
    case (head_i.addr[SelMsb:SelLsb])
      GpioRegion:  sel = SelGpio;
      TimerRegion: sel = SelTimer;
      IrqRegion:   sel = SelIrq;
      default:     sel = SelNone;
    endcase
  end

  // Every queued request completes in one cycle
  assign pop_o = valid_i;

  assign sel_gpio_o  = valid_i && (sel == SelGpio);
  assign sel_timer_o = valid_i && (sel == SelTimer);
  assign sel_irq_o   = valid_i && (sel == SelIrq);

  assign we_o     = head_i.write;
  assign offset_o = head_i.addr[7:0];
  assign wdata_o  = head_i.wdata;

  // ----------------------------------------
  // Response
  // ----------------------------------------
  always_comb begin
    rsp_d.error = 1'b0;
    rsp_d.rdata = '0;
    case (sel)
      SelGpio:  rsp_d.rdata = rdata_gpio_i;
      SelTimer: rsp_d.rdata = rdata_timer_i;
      SelIrq:   rsp_d.rdata = rdata_irq_i;
      default: begin
        rsp_d.error = 1'b1;
        rsp_d.rdata = AbsentData;
      end
    endcase
    // Writes carry no data back
    if (head_i.write) begin
      rsp_d.rdata = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      rsp_o <= rsp_d;
    end
  end

endmodule

// ==== src/periph_pkg.sv ====
/*
 * Peripheral subsystem definitions
 * Host request and response structs, target select and address map
 */

package periph_pkg;

  // ----------------------------------------
  // Register port types
  // ----------------------------------------
  typedef logic [31:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // One host request
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t wdata;
    logic      write;
  } reg_req_t;

  // One response, error set for absent targets
  typedef struct packed {
    reg_data_t rdata;
    logic      error;
  } reg_rsp_t;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  typedef enum logic [1:0] {
    SelGpio,
    SelTimer,
    SelIrq,
    SelNone
  } periph_sel_e;

  // Target field of the address
  localparam int SelMsb = 11;
  localparam int SelLsb = 8;

  localparam logic [SelMsb-SelLsb:0] GpioRegion  = 4'h0;
  localparam logic [SelMsb-SelLsb:0] TimerRegion = 4'h1;
  localparam logic [SelMsb-SelLsb:0] IrqRegion   = 4'h2;

  // Read data of an unmapped address
  localparam reg_data_t AbsentData = 32'hDEAD_BEEF;

endpackage

// ==== src/periph_top.sv ====
/*
 * Peripheral subsystem top level
 * Credit based host port, request queue, decoder, IRQ controller,
 * compare timers and GPIO
 */

module periph_top import periph_pkg::*; #(
  parameter int ReqDepth  = 4,
  parameter int NumTimers = 2,
  parameter int NumExtIrq = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  input  reg_req_t             req_i,
  output logic                 credit_o,
  output logic                 rsp_valid_o,
  output reg_rsp_t             rsp_o,
  input  logic [NumExtIrq-1:0] irq_ext_i,
  input  logic [7:0]           dip_i,
  output logic [7:0]           leds_o,
  output logic                 irq_o
);

  reg_req_t             head;
  logic                 head_valid;
  logic                 pop;
  logic                 sel_gpio;
  logic                 sel_timer;
  logic                 sel_irq;
  logic                 we;
  logic [7:0]           offset;
  reg_data_t            wdata;
  reg_data_t            rdata_gpio;
  reg_data_t            rdata_timer;
  reg_data_t            rdata_irq;
  logic [NumTimers-1:0] timer_irq;

  // ----------------------------------------
  // Host side
  // ----------------------------------------
  req_queue #(
    .ReqDepth ( ReqDepth )
  ) i_req_queue (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .push_i      ( req_valid_i ),
    .push_data_i ( req_i       ),
    .pop_i       ( pop         ),
    .head_o      ( head        ),
    .valid_o     ( head_valid  ),
    .credit_o    ( credit_o    )
  );

  periph_decoder i_periph_decoder (
    .clk_i         ( clk_i       ),
    .rst_n_i       ( rst_n_i     ),
    .head_i        ( head        ),
    .valid_i       ( head_valid  ),
    .pop_o         ( pop         ),
    .sel_gpio_o    ( sel_gpio    ),
    .sel_timer_o   ( sel_timer   ),
    .sel_irq_o     ( sel_irq     ),
    .we_o          ( we          ),
    .offset_o      ( offset      ),
    .wdata_o       ( wdata       ),
    .rdata_gpio_i  ( rdata_gpio  ),
    .rdata_timer_i ( rdata_timer ),
    .rdata_irq_i   ( rdata_irq   ),
    .rsp_valid_o   ( rsp_valid_o ),
    .rsp_o         ( rsp_o       )
  );

  // ----------------------------------------
  // Peripherals
  // ----------------------------------------
  // Timers are the low IRQ sources, external lines follow
  irq_ctrl #(
    .NumSrc ( NumTimers + NumExtIrq )
  ) i_irq_ctrl (
    .clk_i    ( clk_i                  ),
    .rst_n_i  ( rst_n_i                ),
    .sel_i    ( sel_irq                ),
    .we_i     ( we                     ),
    .offset_i ( offset                 ),
    .wdata_i  ( wdata                  ),
    .rdata_o  ( rdata_irq              ),
    .src_i    ( {irq_ext_i, timer_irq} ),
    .irq_o    ( irq_o                  )
  );

  timer_bank #(
    .NumTimers ( NumTimers )
  ) i_timer_bank (
    .clk_i    ( clk_i       ),
    .rst_n_i  ( rst_n_i     ),
    .sel_i    ( sel_timer   ),
    .we_i     ( we          ),
    .offset_i ( offset      ),
    .wdata_i  ( wdata       ),
    .rdata_o  ( rdata_timer ),
    .irq_o    ( timer_irq   )
  );

  gpio_regs i_gpio_regs (
    .clk_i    ( clk_i      ),
    .rst_n_i  ( rst_n_i    ),
    .sel_i    ( sel_gpio   ),
    .we_i     ( we         ),
    .offset_i ( offset     ),
    .wdata_i  ( wdata      ),
    .rdata_o  ( rdata_gpio ),
    .dip_i    ( dip_i      ),
    .leds_o   ( leds_o     )
  );

endmodule

// ==== src/req_queue.sv ====
/*
 * Request queue
 * Circular buffer of host requests, one credit returned per pop
 */

module req_queue import periph_pkg::*; #(
  parameter int ReqDepth = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  reg_req_t push_data_i,
  input  logic     pop_i,
  output reg_req_t head_o,
  output logic     valid_o,
  output logic     credit_o
);

  localparam int PtrW = (ReqDepth > 1) ? $clog2(ReqDepth) : 1;
  localparam int CntW = $clog2(ReqDepth + 1);

  reg_req_t        mem [ReqDepth];
  logic [PtrW-1:0] wr_ptr;
  logic [PtrW-1:0] rd_ptr;
  logic [CntW-1:0] count;

  function automatic logic [PtrW-1:0] ptr_inc(logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(ReqDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Storage, no full check since the host obeys its credits
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count    <= count + CntW'(push_i) - CntW'(pop_i);
      credit_o <= pop_i;
    end
  end

  assign head_o  = mem[rd_ptr];
  assign valid_o = (count != '0);

endmodule

// ==== src/timer_bank.sv ====
/*
 * Compare timer bank
 * Free running counters with enable, load and compare value
 */

module timer_bank import periph_pkg::*; #(
  parameter int NumTimers = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 sel_i,
  input  logic                 we_i,
  input  logic [7:0]           offset_i,
  input  reg_data_t            wdata_i,
  output reg_data_t            rdata_o,
  output logic [NumTimers-1:0] irq_o
);

  localparam logic [3:0] OffCtrl  = 4'h0;
  localparam logic [3:0] OffCount = 4'h4;
  localparam logic [3:0] OffCmp   = 4'h8;

  logic [NumTimers-1:0] en_q;
  reg_data_t            count_q [NumTimers];
  reg_data_t            cmp_q   [NumTimers];
  logic [3:0]           idx;
  logic [3:0]           reg_off;

  // Each timer owns a 16 byte window
  assign idx     = offset_i[7:4];
  assign reg_off = offset_i[3:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q <= '0;
      for (int i = 0; i < NumTimers; i++) begin
        count_q[i] <= '0;
        cmp_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < NumTimers; i++) begin
        if (en_q[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
        // Host write overrides the count step
        if (sel_i && we_i && (idx == 4'(i))) begin
          case (reg_off)
            OffCtrl:  en_q[i]    <= wdata_i[0];
            OffCount: count_q[i] <= wdata_i;
            OffCmp:   cmp_q[i]   <= wdata_i;
            default:  ;
          endcase
        end
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < NumTimers; i++) begin
      if (idx == 4'(i)) begin
        case (reg_off)
          OffCtrl:  rdata_o = {31'b0, en_q[i]};
          OffCount: rdata_o = count_q[i];
          OffCmp:   rdata_o = cmp_q[i];
          default:  rdata_o = '0;
        endcase
      end
    end
  end

  for (genvar g = 0; g < NumTimers; g++) begin : gen_irq
    assign irq_o[g] = en_q[g] && (count_q[g] >= cmp_q[g]);
  end

endmodule

// ==== tb/periph_patterns.txt ====
// op addr wdata exp_rdata exp_error irq_ext test_id
// op: 0 write, 1 read, 2 poll, 3 read DIP, 4 check irq_o, 5 check leds_o, F end; +10 no gap
00 00000000 000000A5 00000000 0 0 1
05 00000000 00000000 000000A5 0 0 1
01 00000000 00000000 000000A5 0 0 1
03 00000004 00000000 00000000 0 0 1
00 00000000 0000003C 00000000 0 0 1
01 00000000 00000000 0000003C 0 0 1
05 00000000 00000000 0000003C 0 0 1
01 00000300 00000000 DEADBEEF 1 0 2
01 00000F04 00000000 DEADBEEF 1 0 2
00 00000300 12345678 00000000 1 0 2
00 00000A10 00000001 00000000 1 0 2
00 00000204 00000001 00000000 0 0 3
00 00000104 00000000 00000000 0 0 3
00 00000108 00000010 00000000 0 0 3
01 00000108 00000000 00000010 0 0 3
00 00000100 00000001 00000000 0 0 3
02 00000200 00000000 00000001 0 0 3
04 00000000 00000000 00000001 0 0 3
00 00000100 00000000 00000000 0 0 3
01 00000208 00000000 00000001 0 0 3
01 00000200 00000000 00000000 0 0 3
04 00000000 00000000 00000000 0 0 3
00 00000204 00000000 00000000 0 0 4
01 00000204 00000000 00000000 0 1 4
01 00000204 00000000 00000000 0 0 4
01 00000200 00000000 00000004 0 0 4
04 00000000 00000000 00000000 0 0 4
01 00000208 00000000 00000000 0 0 4
00 00000204 00000004 00000000 0 0 4
04 00000000 00000000 00000001 0 0 4
01 00000208 00000000 00000003 0 0 4
04 00000000 00000000 00000000 0 0 4
01 00000204 00000000 00000004 0 2 4
01 00000204 00000000 00000004 0 0 4
04 00000000 00000000 00000000 0 0 4
00 00000204 0000000C 00000000 0 0 4
04 00000000 00000000 00000001 0 0 4
01 00000208 00000000 00000004 0 0 4
04 00000000 00000000 00000000 0 0 4
10 00000000 00000011 00000000 0 0 5
11 00000000 00000000 00000011 0 0 5
10 00000000 00000022 00000000 0 0 5
11 00000000 00000000 00000022 0 0 5
11 00000204 00000000 0000000C 0 0 5
11 00000300 00000000 DEADBEEF 1 0 5
11 00000108 00000000 00000010 0 0 5
13 00000004 00000000 00000000 0 0 5
05 00000000 00000000 00000022 0 0 5
0F 00000000 00000000 00000000 0 0 0

// ==== tb/tb_periph.sv ====
/*
 * Peripheral subsystem testbench
 * Plays the pattern file through the credit based host port
 * and checks responses, LEDs and the interrupt output
 */

module tb_periph import periph_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ReqDepth   = 4;
  localparam int NumTimers  = 2;
  localparam int NumExtIrq  = 2;
  localparam int Seed       = 90996;
  localparam int MaxPat     = 64;
  localparam int PatWords   = 7;
  localparam int PollCycles = 400;

  localparam logic [3:0] OpWrite = 4'h0;
  localparam logic [3:0] OpRead  = 4'h1;
  localparam logic [3:0] OpPoll  = 4'h2;
  localparam logic [3:0] OpDip   = 4'h3;
  localparam logic [3:0] OpIrq   = 4'h4;
  localparam logic [3:0] OpLeds  = 4'h5;
  localparam logic [3:0] OpEnd   = 4'hF;

  typedef struct packed {
    reg_rsp_t   rsp;
    logic       check;
    logic [7:0] id;
  } exp_t;

  logic                 clk_i;
  logic                 rst_n_i;
  logic                 req_valid_i;
  reg_req_t             req_i;
  logic                 credit_o;
  logic                 rsp_valid_o;
  reg_rsp_t             rsp_o;
  logic [NumExtIrq-1:0] irq_ext_i;
  logic [7:0]           dip_i;
  logic [7:0]           leds_o;
  logic                 irq_o;

  logic [31:0] pat_mem [MaxPat*PatWords];
  exp_t        exp_q [$];
  reg_rsp_t    last_rsp;
  logic [7:0]  dip_val;
  int          credits;
  int          credit_pulses;
  int          sent;
  int          num_pat;
  int          cycle_count;
  int          timeout_cycles;

  periph_top #(
    .ReqDepth  ( ReqDepth  ),
    .NumTimers ( NumTimers ),
    .NumExtIrq ( NumExtIrq )
  ) periph_top_inst (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .credit_o    ( credit_o    ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_o       ( rsp_o       ),
    .irq_ext_i   ( irq_ext_i   ),
    .dip_i       ( dip_i       ),
    .leds_o      ( leds_o      ),
    .irq_o       ( irq_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Failure handling and compare tasks
  // ----------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic string test_name(input logic [7:0] id);
    case (id)
      8'd1:    return "gpio";
      8'd2:    return "unmapped";
      8'd3:    return "timer_irq";
      8'd4:    return "irq_mask";
      8'd5:    return "flow_control";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_rsp(input string name, input reg_rsp_t exp, input reg_rsp_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s: expected rdata %h error %b, actual rdata %h error %b",
                         name, exp.rdata, exp.error, act.rdata, act.error));
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s: expected irq_o %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_leds(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      fail_run($sformatf("ERROR %s: expected leds_o %h, actual %h", name, exp, act));
    end
  endtask

  // ----------------------------------------
  // Watchdog and response monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > timeout_cycles) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d responses outstanding",
                         cycle_count, exp_q.size()));
    end
  end

  always @(negedge clk_i) begin : rsp_monitor
    exp_t e;
    if (rst_n_i && rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        fail_run("A response arrived with no request outstanding");
      end else begin
        e = exp_q.pop_front();
        last_rsp = rsp_o;
        if (e.check) begin
          check_rsp(test_name(e.id), e.rsp, rsp_o);
        end
      end
    end
    if (rst_n_i && credit_o) begin
      credits++;
      credit_pulses++;
      if (credits > ReqDepth) begin
        fail_run("The DUT returned more credits than the host spent");
      end
    end
  end

  // ----------------------------------------
  // Host side
  // ----------------------------------------
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_gap();
    repeat ($urandom_range(2, 0)) step();
  endtask

  task automatic drain();
    while (exp_q.size() != 0) step();
  endtask

  task automatic send_req(input logic write, input reg_addr_t addr, input reg_data_t wdata,
                          input reg_rsp_t exp, input logic check, input logic [7:0] id);
    exp_t e;
    // Only send while holding a credit
    while (credits == 0) step();
    req_i.addr  = addr;
    req_i.wdata = wdata;
    req_i.write = write;
    req_valid_i = 1'b1;
    credits--;
    sent++;
    e.rsp   = exp;
    e.check = check;
    e.id    = id;
    exp_q.push_back(e);
    step();
    req_valid_i = 1'b0;
  endtask

  task automatic poll_read(input reg_addr_t addr, input reg_rsp_t exp, input logic [7:0] id);
    int start_cycle;
    start_cycle = cycle_count;
    do begin
      send_req(1'b0, addr, '0, exp, 1'b0, id);
      drain();
    end while (last_rsp.rdata !== exp.rdata && cycle_count - start_cycle <= PollCycles);
    if (last_rsp.rdata !== exp.rdata) begin
      fail_run($sformatf("Polling address %h never returned %h", addr, exp.rdata));
    end else begin
      check_rsp(test_name(id), exp, last_rsp);
    end
  endtask

  task automatic run_pattern(input int p);
    logic [7:0]           op;
    reg_addr_t            addr;
    reg_data_t            wdata;
    reg_rsp_t             exp;
    logic [NumExtIrq-1:0] ext;
    logic [7:0]           id;
    op        = pat_mem[p*PatWords][7:0];
    addr      = pat_mem[p*PatWords+1];
    wdata     = pat_mem[p*PatWords+2];
    exp.rdata = pat_mem[p*PatWords+3];
    exp.error = pat_mem[p*PatWords+4][0];
    ext       = pat_mem[p*PatWords+5][NumExtIrq-1:0];
    id        = pat_mem[p*PatWords+6][7:0];
    // Bit 4 of the op marks a back to back request
    if (!op[4]) begin
      idle_gap();
    end
    irq_ext_i = ext;
    case (op[3:0])
      OpWrite: send_req(1'b1, addr, wdata, exp, 1'b1, id);
      OpRead:  send_req(1'b0, addr, '0, exp, 1'b1, id);
      OpPoll:  poll_read(addr, exp, id);
      OpDip: begin
        exp.rdata = {24'b0, dip_val};
        send_req(1'b0, addr, '0, exp, 1'b1, id);
      end
      OpIrq: begin
        drain();
        // irq_o trails the last register update by one edge
        repeat (2) step();
        check_irq(test_name(id), exp.rdata[0], irq_o);
      end
      OpLeds: begin
        drain();
        check_leds(test_name(id), exp.rdata[7:0], leds_o);
      end
      default: fail_run($sformatf("Pattern %0d has an unknown operation %h", p, op));
    endcase
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(Seed));
    dip_val        = 8'($urandom);
    rst_n_i        = 1'b0;
    req_valid_i    = 1'b0;
    req_i          = '0;
    irq_ext_i      = '0;
    dip_i          = dip_val;
    credits        = ReqDepth;
    credit_pulses  = 0;
    sent           = 0;
    cycle_count    = 0;
    last_rsp       = '0;

    $readmemh("tb/periph_patterns.txt", pat_mem);
    num_pat = -1;
    for (int i = 0; i < MaxPat; i++) begin
      if (num_pat < 0 && pat_mem[i*PatWords][3:0] == OpEnd) begin
        num_pat = i;
      end
    end
    if (num_pat < 0) begin
      fail_run("The pattern file has no end marker");
    end
    timeout_cycles = num_pat * 64 + PollCycles;

    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    for (int p = 0; p < num_pat; p++) begin
      run_pattern(p);
    end
    drain();

    if (credit_pulses == sent) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run($sformatf("Credit count off: %0d pulses for %0d requests, %0d credits held",
                         credit_pulses, sent, credits));
    end
  end

endmodule
